// File: logic/fog_defines.svh
`ifndef FOG_DEFINES_SVH
`define FOG_DEFINES_SVH

// adc sample width, adc assumed on CLOCK_DAC_1
`define FOG_ADC_W 14

// dac word width
`define FOG_DAC_W 16

// error, step and ramp words
`define FOG_WORD_W 32

// half-period and settling counters
`define FOG_CNT_W 16

// averaging select, 0..4 gives 1..16 samples
`define FOG_AVG_SEL_W 3

// integrator right-shift amount
`define FOG_GAIN_W 5

`endif

// File: logic/fog_pkg.sv
`include "fog_defines.svh"

package fog_pkg;

	// which half of the square wave is active
	// high half comes first after reset
	typedef enum logic [0:0] {
		MOD_HIGH = 1'b0,
		MOD_LOW  = 1'b1
	} mod_phase_e;

	// demodulator sequencing within one half
	typedef enum logic [1:0] {
		ST_WAIT = 2'd0,
		ST_SUM  = 2'd1,
		ST_DONE = 2'd2
	} demod_state_e;

	// signed data words
	typedef logic signed [`FOG_ADC_W-1:0]  adc_t;
	typedef logic signed [`FOG_WORD_W-1:0] word_t;
	typedef logic signed [`FOG_DAC_W-1:0]  amp_t;

endpackage

// File: logic/mod_square_gen.sv
`timescale 1ns/100ps
`include "fog_defines.svh"

module mod_square_gen
	import fog_pkg::*;
(
	input  logic                  CLOCK_DAC_1,
	input  logic                  i_arst_n,
	input  logic [`FOG_CNT_W-1:0] i_half_period,
	input  amp_t                  i_amp_high,
	input  amp_t                  i_amp_low,
	output mod_phase_e            o_phase,
	output amp_t                  o_mod_out,
	output logic                  o_mod_trig
);

	// cycles spent in the current half
	logic [`FOG_CNT_W-1:0] half_cnt;
	// last cycle of the half
	logic                  half_end;
	// phase for the coming cycle
	mod_phase_e            phase_nxt;

	// >= so a shortened half period takes effect at once
	assign half_end = (half_cnt >= i_half_period - 1'b1);

	always_comb begin
		phase_nxt = o_phase;
		// flip at end of each half
		if (half_end) begin
			phase_nxt = (o_phase == MOD_HIGH) ? MOD_LOW : MOD_HIGH;
		end
	end

	always_ff @(posedge CLOCK_DAC_1 or negedge i_arst_n) begin
		if (!i_arst_n) begin
			half_cnt   <= '0;
			o_phase    <= MOD_HIGH;
			o_mod_out  <= '0;
			o_mod_trig <= 1'b0;
		end else begin
			// wrap counter at half period
			if (half_end) begin
				half_cnt <= '0;
			end else begin
				half_cnt <= half_cnt + 1'b1;
			end
			o_phase <= phase_nxt;
			// one-cycle switch pulse, same edge as phase change
			o_mod_trig <= half_end;
			// amplitude follows the new phase
			if (phase_nxt == MOD_HIGH) begin
				o_mod_out <= i_amp_high;
			end else begin
				o_mod_out <= i_amp_low;
			end
		end
	end

endmodule

// File: logic/err_demod.sv
`timescale 1ns/100ps
`include "fog_defines.svh"

module err_demod
	import fog_pkg::*;
(
	input  logic                      CLOCK_DAC_1,
	input  logic                      i_arst_n,
	input  adc_t                      i_adc,
	input  mod_phase_e                i_phase,
	input  logic                      i_mod_trig,
	input  logic [`FOG_CNT_W-1:0]     i_wait_cnt,
	input  logic [`FOG_AVG_SEL_W-1:0] i_avg_sel,
	input  logic                      i_polarity,
	input  word_t                     i_err_offset,
	output word_t                     o_err,
	output logic                      o_err_valid
);

	demod_state_e state;
	// settling counter
	logic [`FOG_CNT_W-1:0]     wait_cnt;
	// samples taken so far, up to 16
	logic [`FOG_AVG_SEL_W+1:0] samp_cnt;
	// window length, 1 << avg_sel
	logic [`FOG_AVG_SEL_W+1:0] win_len;
	logic                      win_last;
	// running sum and its next value
	word_t                     sum;
	word_t                     sum_nxt;
	// window average incl. current sample
	word_t                     avg;
	// stored average of the high half
	word_t                     high_avg;
	// high minus low, before polarity
	word_t                     diff;
	word_t                     err_nxt;

	assign win_len  = {{(`FOG_AVG_SEL_W+1){1'b0}}, 1'b1} << i_avg_sel;
	assign win_last = (samp_cnt == win_len - 1'b1);

	// sign-extend the sample into the accumulator
	assign sum_nxt = sum + word_t'(i_adc);
	// window is a power of two, shift instead of divide
	assign avg     = sum_nxt >>> i_avg_sel;

	// error is formed at the end of the low half
	assign diff    = high_avg - avg;
	assign err_nxt = (i_polarity ? -diff : diff) + i_err_offset;

	always_ff @(posedge CLOCK_DAC_1 or negedge i_arst_n) begin
		if (!i_arst_n) begin
			// first high half is measured like any other
			state       <= ST_WAIT;
			wait_cnt    <= '0;
			samp_cnt    <= '0;
			o_err       <= '0;
			o_err_valid <= 1'b0;
		end else begin
			o_err_valid <= 1'b0;
			if (i_mod_trig) begin
				// new half, start settling again
				state    <= ST_WAIT;
				wait_cnt <= '0;
				samp_cnt <= '0;
			end else begin
				case (state)
					ST_WAIT: begin
						// wait for the modulation step to settle
						if (wait_cnt >= i_wait_cnt) begin
							state    <= ST_SUM;
							samp_cnt <= '0;
						end else begin
							wait_cnt <= wait_cnt + 1'b1;
						end
					end
					ST_SUM: begin
						samp_cnt <= samp_cnt + 1'b1;
						if (win_last) begin
							state <= ST_DONE;
							// low half closes the period
							if (i_phase == MOD_LOW) begin
								o_err       <= err_nxt;
								o_err_valid <= 1'b1;
							end
						end
					end
					ST_DONE: begin
						// idle until next switch pulse
						state <= ST_DONE;
					end
					default: begin
						state <= ST_DONE;
					end
				endcase
			end
		end
	end

	// accumulator and high-half average
	always_ff @(posedge CLOCK_DAC_1) begin
		if (state == ST_WAIT) begin
			sum <= '0;
		end else if (state == ST_SUM) begin
			sum <= sum_nxt;
		end
		if (state == ST_SUM && win_last && !i_mod_trig && i_phase == MOD_HIGH) begin
			high_avg <= avg;
		end
	end

endmodule

// File: logic/fb_step_integ.sv
`timescale 1ns/100ps
`include "fog_defines.svh"

module fb_step_integ
	import fog_pkg::*;
(
	input  logic                   CLOCK_DAC_1,
	input  logic                   i_arst_n,
	input  word_t                  i_err,
	input  logic                   i_err_valid,
	input  logic                   i_fb_on,
	input  logic [`FOG_GAIN_W-1:0] i_gain_sel,
	input  word_t                  i_const_step,
	output word_t                  o_step,
	output logic                   o_step_valid
);

	// error scaled by the loop gain
	word_t err_scaled;
	// integrated step, wraps at 32 bits
	word_t step_sum;

	// arithmetic shift keeps the sign of the error
	assign err_scaled = i_err >>> i_gain_sel;
	assign step_sum   = o_step + err_scaled;

	always_ff @(posedge CLOCK_DAC_1 or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_step       <= '0;
			o_step_valid <= 1'b0;
		end else begin
			// valid trails the error pulse by one cycle
			o_step_valid <= i_err_valid;
			if (i_err_valid) begin
				if (i_fb_on) begin
					// closed loop, integrate
					o_step <= step_sum;
				end else begin
					// open loop, fixed ramp rate
					o_step <= i_const_step;
				end
			end
		end
	end

endmodule

// File: logic/phase_ramp_gen.sv
`timescale 1ns/100ps
`include "fog_defines.svh"

module phase_ramp_gen
	import fog_pkg::*;
(
	input  logic                  CLOCK_DAC_1,
	input  logic                  i_arst_n,
	input  word_t                 i_step,
	input  logic                  i_step_valid,
	input  amp_t                  i_mod,
	output logic [`FOG_DAC_W-1:0] o_dac
);

	// phase ramp accumulator, wraps at 32 bits
	word_t                 ramp;
	// top bits of the ramp go to the dac
	logic [`FOG_DAC_W-1:0] ramp_hi;
	logic [`FOG_DAC_W-1:0] dac_nxt;

	assign ramp_hi = ramp[`FOG_WORD_W-1 -: `FOG_DAC_W];
	// modulation rides on top of the ramp, 16-bit wrap
	assign dac_nxt = ramp_hi + $unsigned(i_mod);

	always_ff @(posedge CLOCK_DAC_1 or negedge i_arst_n) begin
		if (!i_arst_n) begin
			ramp <= '0;
		end else if (i_step_valid) begin
			// advance once per modulation period
			ramp <= ramp + i_step;
		end
	end

	// registered dac word
	// uses ramp and modulation of the previous cycle
	always_ff @(posedge CLOCK_DAC_1 or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_dac <= '0;
		end else begin
			o_dac <= dac_nxt;
		end
	end

endmodule

// File: logic/fog_loop_top.sv
`timescale 1ns/100ps
`include "fog_defines.svh"

module fog_loop_top
	import fog_pkg::*;
(
	input  logic                      CLOCK_DAC_1,
	input  logic                      i_arst_n,
	input  adc_t                      i_adc,
	input  logic [`FOG_CNT_W-1:0]     i_half_period,
	input  amp_t                      i_amp_high,
	input  amp_t                      i_amp_low,
	input  logic [`FOG_CNT_W-1:0]     i_wait_cnt,
	input  logic [`FOG_AVG_SEL_W-1:0] i_avg_sel,
	input  logic                      i_polarity,
	input  word_t                     i_err_offset,
	input  logic                      i_fb_on,
	input  logic [`FOG_GAIN_W-1:0]    i_gain_sel,
	input  word_t                     i_const_step,
	output logic                      o_mod_trig,
	output word_t                     o_err,
	output logic                      o_err_valid,
	output word_t                     o_step,
	output logic [`FOG_DAC_W-1:0]     o_dac
);

	// modulation half seen by the demodulator
	mod_phase_e mod_phase;
	// modulation amplitude added to the ramp
	amp_t       mod_out;
	// step update strobe into the ramp
	logic       step_valid;

	// square-wave modulation
	mod_square_gen u_mod_square_gen (
		.CLOCK_DAC_1   (CLOCK_DAC_1),
		.i_arst_n      (i_arst_n),
		.i_half_period (i_half_period),
		.i_amp_high    (i_amp_high),
		.i_amp_low     (i_amp_low),
		.o_phase       (mod_phase),
		.o_mod_out     (mod_out),
		.o_mod_trig    (o_mod_trig)
	);

	// error demodulation, one error per period
	err_demod u_err_demod (
		.CLOCK_DAC_1  (CLOCK_DAC_1),
		.i_arst_n     (i_arst_n),
		.i_adc        (i_adc),
		.i_phase      (mod_phase),
		.i_mod_trig   (o_mod_trig),
		.i_wait_cnt   (i_wait_cnt),
		.i_avg_sel    (i_avg_sel),
		.i_polarity   (i_polarity),
		.i_err_offset (i_err_offset),
		.o_err        (o_err),
		.o_err_valid  (o_err_valid)
	);

	// feedback integrator
	fb_step_integ u_fb_step_integ (
		.CLOCK_DAC_1  (CLOCK_DAC_1),
		.i_arst_n     (i_arst_n),
		.i_err        (o_err),
		.i_err_valid  (o_err_valid),
		.i_fb_on      (i_fb_on),
		.i_gain_sel   (i_gain_sel),
		.i_const_step (i_const_step),
		.o_step       (o_step),
		.o_step_valid (step_valid)
	);

	// phase ramp and dac word
	phase_ramp_gen u_phase_ramp_gen (
		.CLOCK_DAC_1  (CLOCK_DAC_1),
		.i_arst_n     (i_arst_n),
		.i_step       (o_step),
		.i_step_valid (step_valid),
		.i_mod        (mod_out),
		.o_dac        (o_dac)
	);

endmodule

// File: sim/tb_fog_model.svh
`ifndef TB_FOG_MODEL_SVH
`define TB_FOG_MODEL_SVH

// model phase from the switch pulses
mod_phase_e m_phase;
// adc values held over the last high and low half
word_t      m_high_val;
word_t      m_low_val;
// step and ramp the dut should hold
word_t      m_step;
// step waiting to land
word_t      m_step_new;
word_t      m_ramp;
// pipeline flags behind an error pulse
logic       m_step_dly;
logic       m_ramp_dly;

// model state right after reset
task automatic reset_model(input adc_t first_val);
	m_phase    = MOD_HIGH;
	m_high_val = word_t'(first_val);
	m_low_val  = '0;
	m_step     = '0;
	m_step_new = '0;
	m_ramp     = '0;
	m_step_dly = 1'b0;
	m_ramp_dly = 1'b0;
endtask

// new half starts with adc held at new_val
task automatic switch_half(input adc_t new_val);
	if (m_phase == MOD_HIGH) begin
		m_phase   = MOD_LOW;
		m_low_val = word_t'(new_val);
	end else begin
		m_phase    = MOD_HIGH;
		m_high_val = word_t'(new_val);
	end
endtask

// averaging a constant returns the constant for any window
function automatic word_t expected_error(input logic pol, input word_t offset);
	word_t diff;
	diff = m_high_val - m_low_val;
	// inverted loop sense
	if (pol) begin
		diff = -diff;
	end
	return diff + offset;
endfunction

// error pulse reaches the integrator
task automatic take_error(input word_t err_in, input logic fb,
		input logic [`FOG_GAIN_W-1:0] gain, input word_t cstep);
	if (fb) begin
		// closed loop adds the scaled error
		m_step_new = m_step + (err_in >>> gain);
	end else begin
		// open loop loads the constant
		m_step_new = cstep;
	end
	m_step_dly = 1'b1;
endtask

// one clock of the model
// step lands a cycle after the error and the ramp a cycle after that
task automatic advance_model();
	// ramp moves by the step that landed last cycle
	if (m_ramp_dly) begin
		m_ramp     = m_ramp + m_step;
		m_ramp_dly = 1'b0;
	end
	if (m_step_dly) begin
		m_step     = m_step_new;
		m_step_dly = 1'b0;
		m_ramp_dly = 1'b1;
	end
endtask

`endif

// File: sim/tb_fog_loop.sv
`timescale 1ns/100ps
`include "fog_defines.svh"

module tb_fog_loop
	import fog_pkg::*;
();

	logic                      CLOCK_DAC_1;
	logic                      arst_n;
	adc_t                      adc;
	logic [`FOG_CNT_W-1:0]     half_period;
	amp_t                      amp_high;
	amp_t                      amp_low;
	logic [`FOG_CNT_W-1:0]     wait_cnt;
	logic [`FOG_AVG_SEL_W-1:0] avg_sel;
	logic                      polarity;
	word_t                     err_offset;
	logic                      fb_on;
	logic [`FOG_GAIN_W-1:0]    gain_sel;
	word_t                     const_step;
	logic                      mod_trig;
	word_t                     err;
	logic                      err_valid;
	word_t                     step;
	logic [`FOG_DAC_W-1:0]     dac;
	integer                    seed;
	int                        error_cnt;
	int                        timeout_cnt;

	`include "tb_fog_model.svh"

	fog_loop_top dut0 (
		.CLOCK_DAC_1   (CLOCK_DAC_1),
		.i_arst_n      (arst_n),
		.i_adc         (adc),
		.i_half_period (half_period),
		.i_amp_high    (amp_high),
		.i_amp_low     (amp_low),
		.i_wait_cnt    (wait_cnt),
		.i_avg_sel     (avg_sel),
		.i_polarity    (polarity),
		.i_err_offset  (err_offset),
		.i_fb_on       (fb_on),
		.i_gain_sel    (gain_sel),
		.i_const_step  (const_step),
		.o_mod_trig    (mod_trig),
		.o_err         (err),
		.o_err_valid   (err_valid),
		.o_step        (step),
		.o_dac         (dac)
	);

	// 8 ns period
	initial begin
		CLOCK_DAC_1 = 1'b0;
		forever #4 CLOCK_DAC_1 = ~CLOCK_DAC_1;
	end

	function automatic int rand_between(input int lo, input int hi);
		logic [31:0] r;
		r = $random(seed);
		return lo + int'(r % (hi - lo + 1));
	endfunction

	task automatic compare_val(input string name, input logic [31:0] act,
			input logic [31:0] exp);
		if (act !== exp) begin
			error_cnt++;
			$display("error at %0t: %s actual %h expected %h", $time, name, act, exp);
		end
	endtask

	// all loop outputs quiet
	task automatic check_idle();
		compare_val("o_mod_trig", 32'(mod_trig), 32'd0);
		compare_val("o_err_valid", 32'(err_valid), 32'd0);
		compare_val("o_err", err, 32'd0);
		compare_val("o_step", step, 32'd0);
		compare_val("o_dac", 32'(dac), 32'd0);
	endtask

	// one reset plus n_err error pulses with fresh settings
	task automatic run_once(input logic fb, input int n_err);
		int hp_min;
		int cyc;
		int trig_gap;
		int err_seen;
		int half_errs;
		int limit;
		word_t err_exp;
		logic [`FOG_DAC_W-1:0] dac_exp;
		@(negedge CLOCK_DAC_1);
		wait_cnt = rand_between(2, 5);
		avg_sel  = rand_between(0, 4);
		// leave room for the error to reach the ramp before the next switch
		hp_min = wait_cnt + (1 << avg_sel) + 8;
		if (hp_min < 24) begin
			hp_min = 24;
		end
		half_period = rand_between(hp_min, 60);
		amp_high    = $random(seed);
		amp_low     = $random(seed);
		polarity    = $random(seed);
		err_offset  = $random(seed);
		gain_sel    = $random(seed);
		const_step  = $random(seed);
		fb_on       = fb;
		adc         = $random(seed);
		arst_n      = 1'b0;
		reset_model(adc);
		for (int i = 0; i < 4; i++) begin
			@(negedge CLOCK_DAC_1);
			check_idle();
		end
		arst_n    = 1'b1;
		cyc       = 0;
		trig_gap  = 0;
		err_seen  = 0;
		half_errs = 0;
		limit     = (n_err + 1) * 2 * half_period + 20;
		// last step update is checked before leaving
		while ((err_seen < n_err || m_step_dly) && cyc < limit) begin
			@(negedge CLOCK_DAC_1);
			cyc++;
			trig_gap++;
			advance_model();
			if (cyc == 1) begin
				check_idle();
			end
			// step moves only one cycle after an error pulse
			compare_val("o_step", step, m_step);
			if (mod_trig) begin
				compare_val("o_mod_trig interval", 32'(trig_gap), 32'(half_period));
				// amplitude of the half that is ending
				dac_exp = m_ramp[31:16] + ((m_phase == MOD_HIGH) ? amp_high : amp_low);
				compare_val("o_dac", 32'(dac), 32'(dac_exp));
				// one error per low half and none in a high half
				compare_val("o_err_valid count", 32'(half_errs),
					(m_phase == MOD_LOW) ? 32'd1 : 32'd0);
				trig_gap  = 0;
				half_errs = 0;
				// adc held for the whole next half
				adc       = $random(seed);
				switch_half(adc);
			end
			if (err_valid) begin
				err_exp = expected_error(polarity, err_offset);
				compare_val("o_err", err, err_exp);
				take_error(err_exp, fb_on, gain_sel, const_step);
				err_seen++;
				half_errs++;
			end
		end
		if (err_seen < n_err || m_step_dly) begin
			timeout_cnt++;
			$display("timeout: only %0d of %0d error pulses seen in %0d cycles",
				err_seen, n_err, limit);
		end
	endtask

	initial begin
		seed        = 32'h237d8867;
		error_cnt   = 0;
		timeout_cnt = 0;
		arst_n      = 1'b0;
		adc         = '0;
		half_period = 16'd24;
		amp_high    = '0;
		amp_low     = '0;
		wait_cnt    = '0;
		avg_sel     = '0;
		polarity    = 1'b0;
		err_offset  = '0;
		fb_on       = 1'b0;
		gain_sel    = '0;
		const_step  = '0;
		// first run open loop and the rest closed
		run_once(1'b0, 6);
		for (int run = 0; run < 4; run++) begin
			run_once(1'b1, 6);
		end
		$display("done with %0d errors and %0d timeouts", error_cnt, timeout_cnt);
		if (error_cnt == 0 && timeout_cnt == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

// File: list.f
+incdir+logic
+incdir+sim
logic/fog_pkg.sv
logic/mod_square_gen.sv
logic/err_demod.sv
logic/fb_step_integ.sv
logic/phase_ramp_gen.sv
logic/fog_loop_top.sv
sim/tb_fog_loop.sv

// File: Bender.yml
package:
  name: fog_loop

export_include_dirs:
  - logic

sources:
  - logic/fog_pkg.sv
  - logic/mod_square_gen.sv
  - logic/err_demod.sv
  - logic/fb_step_integ.sv
  - logic/phase_ramp_gen.sv
  - logic/fog_loop_top.sv
  - target: test
    include_dirs:
      - sim
    files:
      - sim/tb_fog_loop.sv
